//--- Bender.yml
package:
  name: csr_regfile

sources:
  - logic/csr_pkg.sv
  - logic/csr_mode_ctrl.sv
  - logic/csr_timer.sv
  - logic/csr_exc_regs.sv
  - logic/csr_scratch_regs.sv
  - logic/csr_read_port.sv
  - logic/csr_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/csr_tb.sv

//--- logic/csr_exc_regs.sv
`timescale 1ns/100ps

module csr_exc_regs (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_wr_t   csr_wr,
    input  csr_pkg::exc_ctl_t  exc_ctl,
    input  csr_pkg::hw_int_t   hardware_int,
    input  logic               timer_int,
    input  logic               ie,
    output csr_pkg::ecode_t    ecode,
    output csr_pkg::csr_word_t era_out,
    output csr_pkg::csr_word_t eentry,
    output logic               has_interrupt_cpu,
    output logic               has_interrupt_idle,
    output csr_pkg::exc_view_t exc_view
);
    import csr_pkg::*;

    int_vec_t               lie_q;
    logic [1:0]             sw_is_q;
    ecode_t                 ecode_q;
    logic                   esubcode_q;
    csr_word_t              era_q;
    logic [EENTRY_VA_W-1:0] eentry_va_q;
    csr_word_t              lie_new;
    csr_word_t              estat_new;
    csr_word_t              era_new;
    csr_word_t              eentry_new;
    int_vec_t               int_vec;

    always_comb begin
        lie_new    = masked_write(csr_word_t'(lie_q), csr_wr.data, csr_wr.mask & LIE_WMASK);
        estat_new  = masked_write(csr_word_t'(sw_is_q), csr_wr.data, csr_wr.mask);
        era_new    = masked_write(era_q, csr_wr.data, csr_wr.mask);
        eentry_new = masked_write(eentry, csr_wr.data, csr_wr.mask);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lie_q       <= '0;
            eentry_va_q <= '0;
        end else if (csr_wr.en) begin
            if (csr_wr.addr == CSR_ECFG) begin
                lie_q <= lie_new[INT_W-1:0];
            end
            if (csr_wr.addr == CSR_EENTRY) begin
                eentry_va_q <= eentry_new[EENTRY_VA_LSB +: EENTRY_VA_W];
            end
        end
    end

    // exception entry owns estat over software
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sw_is_q    <= '0;
            ecode_q    <= '0;
            esubcode_q <= 1'b0;
        end else if (exc_ctl.ecode_we) begin
            ecode_q    <= exc_ctl.ecode_in[ECODE_W-1:0];
            esubcode_q <= (|exc_ctl.ecode_in[ECODE_W-1:0]) & exc_ctl.ecode_in[ECODE_W];
        end else if (csr_wr.en && csr_wr.addr == CSR_ESTAT) begin
            sw_is_q <= estat_new[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            era_q <= '0;
        end else if (exc_ctl.era_we) begin
            era_q <= exc_ctl.era_in;
        end else if (csr_wr.en && csr_wr.addr == CSR_ERA) begin
            era_q <= era_new;
        end
    end

    ////////////////////////////////////////////////
    // interrupt requests
    ////////////////////////////////////////////////
    // timer at 11, bits 10 and 12 unused
    assign int_vec = {1'b0, timer_int, 1'b0, hardware_int, sw_is_q};

    assign has_interrupt_idle = |int_vec;
    assign has_interrupt_cpu  = ie & (|(lie_q & int_vec));

    assign ecode    = ecode_q;
    assign era_out  = era_q;
    assign eentry   = {eentry_va_q, {EENTRY_VA_LSB{1'b0}}};
    assign exc_view = '{lie: lie_q, sw_is: sw_is_q, ecode: ecode_q, esubcode: esubcode_q,
                        era: era_q, eentry_va: eentry_va_q};

endmodule

//--- logic/csr_mode_ctrl.sv
`timescale 1ns/100ps

module csr_mode_ctrl (
    input  logic                 clk,
    input  logic                 rstn,
    input  csr_pkg::csr_wr_t     csr_wr,
    input  logic                 store_state,
    input  logic                 restore_state,
    output csr_pkg::plv_t        plv,
    output logic                 ie,
    output csr_pkg::trans_mode_e translate_mode,
    output csr_pkg::mode_view_t  mode_view
);
    import csr_pkg::*;

    plv_t        plv_q;
    logic        ie_q;
    plv_t        pplv_q;
    logic        pie_q;
    trans_mode_e mode_q;
    trans_mode_e mode_d;
    logic        crmd_we;
    logic        prmd_we;
    csr_word_t   crmd_cur;
    csr_word_t   crmd_new;
    csr_word_t   prmd_new;
    logic [1:0]  pgda_new;

    assign crmd_we = csr_wr.en && (csr_wr.addr == CSR_CRMD);
    assign prmd_we = csr_wr.en && (csr_wr.addr == CSR_PRMD);

    always_comb begin
        crmd_cur = '0;
        crmd_cur[CRMD_PLV_LSB +: PLV_W] = plv_q;
        crmd_cur[CRMD_IE] = ie_q;
        crmd_cur[CRMD_DA] = mode_q[0];
        crmd_cur[CRMD_PG] = mode_q[1];
        crmd_new = masked_write(crmd_cur, csr_wr.data, csr_wr.mask);
        prmd_new = masked_write(csr_word_t'({pie_q, pplv_q}), csr_wr.data, csr_wr.mask);
        pgda_new = {crmd_new[CRMD_PG], crmd_new[CRMD_DA]};
    end

    ////////////////////////////////////////////////
    // translation mode fsm
    ////////////////////////////////////////////////
    always_comb begin
        mode_d = mode_q;
        if (crmd_we && !store_state && !restore_state) begin
            case (pgda_new)
                TM_DIRECT: mode_d = TM_DIRECT;
                TM_PAGED:  mode_d = TM_PAGED;
                // da == pg is not a legal mode
                default:   mode_d = mode_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            plv_q  <= '0;
            ie_q   <= 1'b0;
            mode_q <= TM_DIRECT;
        end else begin
            mode_q <= mode_d;
            if (restore_state) begin
                plv_q <= pplv_q;
                ie_q  <= pie_q;
            end else if (store_state) begin
                plv_q <= '0;
                ie_q  <= 1'b0;
            end else if (crmd_we) begin
                plv_q <= crmd_new[CRMD_PLV_LSB +: PLV_W];
                ie_q  <= crmd_new[CRMD_IE];
            end
        end
    end

    // previous mode, store is dropped when restore is also set
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pplv_q <= '0;
            pie_q  <= 1'b0;
        end else if (store_state && !restore_state) begin
            pplv_q <= plv_q;
            pie_q  <= ie_q;
        end else if (prmd_we) begin
            pplv_q <= prmd_new[CRMD_PLV_LSB +: PLV_W];
            pie_q  <= prmd_new[CRMD_IE];
        end
    end

    assign plv            = plv_q;
    assign ie             = ie_q;
    assign translate_mode = mode_q;
    assign mode_view      = '{plv: plv_q, ie: ie_q, mode: mode_q, pplv: pplv_q, pie: pie_q};

    a_mode_legal: assert property (@(posedge clk) disable iff (!rstn)
        mode_q inside {TM_DIRECT, TM_PAGED});

endmodule

//--- logic/csr_pkg.sv
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 14;
    localparam int PLV_W      = 2;
    localparam int ECODE_W    = 6;
    localparam int HW_INT_W   = 8;
    localparam int INT_W      = 13;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [XLEN-1:0]       csr_word_t;
    typedef logic [PLV_W-1:0]      plv_t;
    typedef logic [ECODE_W-1:0]    ecode_t;
    typedef logic [HW_INT_W-1:0]   hw_int_t;
    typedef logic [INT_W-1:0]      int_vec_t;
    typedef logic [XLEN-1:0]       tval_t;

    ////////////////////////////////////////////////
    // register addresses
    ////////////////////////////////////////////////
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECFG   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_EENTRY = 14'hc;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;
    localparam csr_addr_t CSR_SAVE1  = 14'h31;
    localparam csr_addr_t CSR_SAVE2  = 14'h32;
    localparam csr_addr_t CSR_SAVE3  = 14'h33;
    localparam csr_addr_t CSR_TID    = 14'h40;
    localparam csr_addr_t CSR_TCFG   = 14'h41;
    localparam csr_addr_t CSR_TVAL   = 14'h42;
    localparam csr_addr_t CSR_TICLR  = 14'h44;

    ////////////////////////////////////////////////
    // field positions
    ////////////////////////////////////////////////
    // prmd shares the plv/ie layout of crmd
    localparam int CRMD_PLV_LSB       = 0;
    localparam int CRMD_IE            = 2;
    localparam int CRMD_DA            = 3;
    localparam int CRMD_PG            = 4;
    localparam int TCFG_EN            = 0;
    localparam int TCFG_PERIODIC      = 1;
    localparam int TCFG_INITVAL_LSB   = 2;
    localparam int TCFG_INITVAL_W     = 30;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int EENTRY_VA_LSB      = 6;
    localparam int EENTRY_VA_W        = 26;
    localparam int TICLR_CLR          = 0;

    // lie bit 10 and bits 31:13 stay zero
    localparam csr_word_t LIE_WMASK = 32'h0000_1bff;

    typedef enum logic [1:0] {
        TM_DIRECT = 2'b01,
        TM_PAGED  = 2'b10
    } trans_mode_e;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_word_t mask;
        csr_word_t data;
    } csr_wr_t;

    typedef struct packed {
        logic           store_state;
        logic           restore_state;
        logic           ecode_we;
        logic [ECODE_W:0] ecode_in;
        logic           era_we;
        csr_word_t      era_in;
    } exc_ctl_t;

    typedef struct packed {
        plv_t        plv;
        logic        ie;
        trans_mode_e mode;
        plv_t        pplv;
        logic        pie;
    } mode_view_t;

    typedef struct packed {
        int_vec_t               lie;
        logic [1:0]             sw_is;
        ecode_t                 ecode;
        logic                   esubcode;
        csr_word_t              era;
        logic [EENTRY_VA_W-1:0] eentry_va;
    } exc_view_t;

    typedef struct packed {
        logic                      en;
        logic                      periodic;
        logic [TCFG_INITVAL_W-1:0] initval;
        tval_t                     tval;
        logic                      timer_int;
    } timer_view_t;

    typedef struct packed {
        csr_word_t save0;
        csr_word_t save1;
        csr_word_t save2;
        csr_word_t save3;
        csr_word_t tid;
    } scratch_view_t;

    // bits under a set mask bit take the new data
    function automatic csr_word_t masked_write(csr_word_t cur, csr_word_t data,
                                               csr_word_t mask);
        return (cur & ~mask) | (data & mask);
    endfunction

endpackage

//--- logic/csr_read_port.sv
`timescale 1ns/100ps

module csr_read_port (
    input  csr_pkg::csr_addr_t     raddr,
    input  csr_pkg::mode_view_t    mode_view,
    input  csr_pkg::exc_view_t     exc_view,
    input  csr_pkg::timer_view_t   timer_view,
    input  csr_pkg::scratch_view_t scratch_view,
    input  csr_pkg::hw_int_t       hardware_int,
    output csr_pkg::csr_word_t     rdata
);
    import csr_pkg::*;

    csr_word_t crmd_w;
    csr_word_t prmd_w;
    csr_word_t estat_w;
    csr_word_t tcfg_w;
    logic      mapped;

    ////////////////////////////////////////////////
    // architectural words
    ////////////////////////////////////////////////
    always_comb begin
        crmd_w = '0;
        crmd_w[CRMD_PLV_LSB +: PLV_W] = mode_view.plv;
        crmd_w[CRMD_IE] = mode_view.ie;
        crmd_w[CRMD_DA] = mode_view.mode[0];
        crmd_w[CRMD_PG] = mode_view.mode[1];

        prmd_w = '0;
        prmd_w[CRMD_PLV_LSB +: PLV_W] = mode_view.pplv;
        prmd_w[CRMD_IE] = mode_view.pie;

        // live interrupt lines in is[12:0]
        estat_w = '0;
        estat_w[INT_W-1:0] = {1'b0, timer_view.timer_int, 1'b0, hardware_int, exc_view.sw_is};
        estat_w[ESTAT_ECODE_LSB +: ECODE_W] = exc_view.ecode;
        estat_w[ESTAT_ESUBCODE_LSB] = exc_view.esubcode;

        tcfg_w = '0;
        tcfg_w[TCFG_EN] = timer_view.en;
        tcfg_w[TCFG_PERIODIC] = timer_view.periodic;
        tcfg_w[TCFG_INITVAL_LSB +: TCFG_INITVAL_W] = timer_view.initval;
    end

    always_comb begin
        case (raddr)
            CSR_CRMD:   rdata = crmd_w;
            CSR_PRMD:   rdata = prmd_w;
            CSR_ECFG:   rdata = csr_word_t'(exc_view.lie);
            CSR_ESTAT:  rdata = estat_w;
            CSR_ERA:    rdata = exc_view.era;
            CSR_EENTRY: rdata = {exc_view.eentry_va, {EENTRY_VA_LSB{1'b0}}};
            CSR_SAVE0:  rdata = scratch_view.save0;
            CSR_SAVE1:  rdata = scratch_view.save1;
            CSR_SAVE2:  rdata = scratch_view.save2;
            CSR_SAVE3:  rdata = scratch_view.save3;
            CSR_TID:    rdata = scratch_view.tid;
            CSR_TCFG:   rdata = tcfg_w;
            CSR_TVAL:   rdata = timer_view.tval;
            // write-only strobe
            CSR_TICLR:  rdata = '0;
            default:    rdata = '0;
        endcase
    end

    assign mapped = raddr inside {CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA,
                                  CSR_EENTRY, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                                  CSR_TID, CSR_TCFG, CSR_TVAL, CSR_TICLR};

    always_comb begin
        if (!mapped) begin
            a_unmapped_zero: assert final (rdata == '0);
        end
    end

endmodule

//--- logic/csr_scratch_regs.sv
`timescale 1ns/100ps

module csr_scratch_regs (
    input  logic                   clk,
    input  logic                   rstn,
    input  csr_pkg::csr_wr_t       csr_wr,
    output csr_pkg::csr_word_t     tid,
    output csr_pkg::scratch_view_t scratch_view
);
    import csr_pkg::*;

    csr_word_t save0_q;
    csr_word_t save1_q;
    csr_word_t save2_q;
    csr_word_t save3_q;
    csr_word_t tid_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            save0_q <= '0;
            save1_q <= '0;
            save2_q <= '0;
            save3_q <= '0;
            tid_q   <= '0;
        end else if (csr_wr.en) begin
            case (csr_wr.addr)
                CSR_SAVE0: save0_q <= masked_write(save0_q, csr_wr.data, csr_wr.mask);
                CSR_SAVE1: save1_q <= masked_write(save1_q, csr_wr.data, csr_wr.mask);
                CSR_SAVE2: save2_q <= masked_write(save2_q, csr_wr.data, csr_wr.mask);
                CSR_SAVE3: save3_q <= masked_write(save3_q, csr_wr.data, csr_wr.mask);
                CSR_TID:   tid_q   <= masked_write(tid_q, csr_wr.data, csr_wr.mask);
                default: ;
            endcase
        end
    end

    assign tid          = tid_q;
    assign scratch_view = '{save0: save0_q, save1: save1_q, save2: save2_q,
                            save3: save3_q, tid: tid_q};

endmodule

//--- logic/csr_timer.sv
`timescale 1ns/100ps

module csr_timer (
    input  logic                 clk,
    input  logic                 rstn,
    input  csr_pkg::csr_wr_t     csr_wr,
    output logic                 timer_int,
    output csr_pkg::timer_view_t timer_view
);
    import csr_pkg::*;

    csr_word_t                 tcfg_q;
    tval_t                     tval_q;
    logic                      tcfg_we;
    logic                      ticlr_hit;
    logic                      reload_pulse;
    logic                      time_out;
    logic                      timer_int_q;
    logic                      tcfg_en;
    logic                      tcfg_periodic;
    logic [TCFG_INITVAL_W-1:0] initval;

    assign tcfg_we   = csr_wr.en && (csr_wr.addr == CSR_TCFG);
    assign ticlr_hit = csr_wr.en && (csr_wr.addr == CSR_TICLR)
                       && csr_wr.mask[TICLR_CLR] && csr_wr.data[TICLR_CLR];

    assign tcfg_en       = tcfg_q[TCFG_EN];
    assign tcfg_periodic = tcfg_q[TCFG_PERIODIC];
    assign initval       = tcfg_q[TCFG_INITVAL_LSB +: TCFG_INITVAL_W];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tcfg_q <= '0;
        end else if (tcfg_we) begin
            tcfg_q <= masked_write(tcfg_q, csr_wr.data, csr_wr.mask);
        end
    end

    // any tcfg write restarts the count
    always_ff @(posedge clk) begin
        if (!rstn) begin
            reload_pulse <= 1'b0;
        end else begin
            reload_pulse <= tcfg_we && (|csr_wr.mask);
        end
    end

    ////////////////////////////////////////////////
    // countdown
    ////////////////////////////////////////////////
    // load value is initval*4 + 1 so that initval 0 still fires
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tval_q   <= '0;
            time_out <= 1'b0;
        end else if (reload_pulse || tval_q == '0) begin
            time_out <= 1'b0;
            if (reload_pulse || tcfg_periodic) begin
                tval_q <= {initval, 2'b01};
            end
        end else if (tcfg_en) begin
            tval_q   <= tval_q - 1'b1;
            time_out <= (tval_q == tval_t'(1));
        end
    end

    // interrupt latch, clear beats a new timeout
    always_ff @(posedge clk) begin
        if (!rstn || ticlr_hit) begin
            timer_int_q <= 1'b0;
        end else if (time_out) begin
            timer_int_q <= 1'b1;
        end
    end

    assign timer_int  = timer_int_q;
    assign timer_view = '{en: tcfg_en, periodic: tcfg_periodic, initval: initval,
                          tval: tval_q, timer_int: timer_int_q};

    a_tval_hold: assert property (@(posedge clk) disable iff (!rstn)
        !tcfg_en && !reload_pulse && tval_q != '0 |=> $stable(tval_q));

endmodule

//--- logic/csr_top.sv
`timescale 1ns/100ps

module csr_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  csr_pkg::csr_wr_t     csr_wr,
    input  csr_pkg::csr_addr_t   raddr,
    output csr_pkg::csr_word_t   rdata,
    input  csr_pkg::exc_ctl_t    exc_ctl,
    input  csr_pkg::hw_int_t     hardware_int,
    output csr_pkg::plv_t        plv,
    output csr_pkg::ecode_t      ecode,
    output csr_pkg::csr_word_t   era_out,
    output csr_pkg::csr_word_t   eentry,
    output logic                 has_interrupt_cpu,
    output logic                 has_interrupt_idle,
    output csr_pkg::trans_mode_e translate_mode,
    output csr_pkg::csr_word_t   tid
);
    import csr_pkg::*;

    logic          ie;
    logic          timer_int;
    mode_view_t    mode_view;
    exc_view_t     exc_view;
    timer_view_t   timer_view;
    scratch_view_t scratch_view;

    csr_mode_ctrl u_mode_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .csr_wr         (csr_wr),
        .store_state    (exc_ctl.store_state),
        .restore_state  (exc_ctl.restore_state),
        .plv            (plv),
        .ie             (ie),
        .translate_mode (translate_mode),
        .mode_view      (mode_view)
    );

    csr_timer u_timer (
        .clk        (clk),
        .rstn       (rstn),
        .csr_wr     (csr_wr),
        .timer_int  (timer_int),
        .timer_view (timer_view)
    );

    csr_exc_regs u_exc_regs (
        .clk                (clk),
        .rstn               (rstn),
        .csr_wr             (csr_wr),
        .exc_ctl            (exc_ctl),
        .hardware_int       (hardware_int),
        .timer_int          (timer_int),
        .ie                 (ie),
        .ecode              (ecode),
        .era_out            (era_out),
        .eentry             (eentry),
        .has_interrupt_cpu  (has_interrupt_cpu),
        .has_interrupt_idle (has_interrupt_idle),
        .exc_view           (exc_view)
    );

    csr_scratch_regs u_scratch_regs (
        .clk          (clk),
        .rstn         (rstn),
        .csr_wr       (csr_wr),
        .tid          (tid),
        .scratch_view (scratch_view)
    );

    csr_read_port u_read_port (
        .raddr        (raddr),
        .mode_view    (mode_view),
        .exc_view     (exc_view),
        .timer_view   (timer_view),
        .scratch_view (scratch_view),
        .hardware_int (hardware_int),
        .rdata        (rdata)
    );

endmodule

//--- test/csr_tb.sv
`timescale 1ns/100ps

module csr_tb;
    import csr_pkg::*;

    localparam int        CYCLE_LIMIT = 2000;
    localparam int        TIMER_INIT  = 3;
    localparam int        TIMER_LAT   = TIMER_INIT * 4 + 4;
    localparam csr_word_t LIE_BITS    = 32'h0000_1bff;

    logic        clk;
    logic        rstn;
    csr_wr_t     csr_wr;
    csr_addr_t   raddr;
    csr_word_t   rdata;
    exc_ctl_t    exc_ctl;
    hw_int_t     hardware_int;
    plv_t        plv;
    ecode_t      ecode;
    csr_word_t   era_out;
    csr_word_t   eentry;
    csr_word_t   tid;
    logic        has_interrupt_cpu;
    logic        has_interrupt_idle;
    trans_mode_e translate_mode;

    // register model
    csr_word_t  m_save [4];
    csr_word_t  m_tid;
    csr_word_t  m_era;
    csr_word_t  m_eentry;
    csr_word_t  m_tcfg;
    int_vec_t   m_lie;
    logic [1:0] m_sw_is;
    ecode_t     m_ecode;
    logic       m_esub;
    plv_t       m_plv;
    plv_t       m_pplv;
    logic       m_ie;
    logic       m_pie;
    logic       m_da;
    logic       m_pg;
    logic       m_timer_int;

    logic      chk_en;
    csr_word_t chk_exp;
    int        err_cnt;
    int        chk_cnt;
    int        cycle_cnt;
    integer    seed;

    tb_clock_gen clock_gen_inst (.clk(clk), .rstn(rstn));

    csr_top csr_top_inst (
        .clk                (clk),
        .rstn               (rstn),
        .csr_wr             (csr_wr),
        .raddr              (raddr),
        .rdata              (rdata),
        .exc_ctl            (exc_ctl),
        .hardware_int       (hardware_int),
        .plv                (plv),
        .ecode              (ecode),
        .era_out            (era_out),
        .eentry             (eentry),
        .has_interrupt_cpu  (has_interrupt_cpu),
        .has_interrupt_idle (has_interrupt_idle),
        .translate_mode     (translate_mode),
        .tid                (tid)
    );

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic csr_word_t merge_bits(csr_word_t old, csr_word_t data, csr_word_t mask);
        csr_word_t r;
        for (int i = 0; i < 32; i++) begin
            r[i] = mask[i] ? data[i] : old[i];
        end
        return r;
    endfunction

    function automatic int_vec_t int_vector();
        return {1'b0, m_timer_int, 1'b0, hardware_int, m_sw_is};
    endfunction

    function automatic csr_word_t expected_rdata(csr_addr_t a);
        csr_word_t r;
        r = '0;
        case (a)
            CSR_CRMD:   r = {27'b0, m_pg, m_da, m_ie, m_plv};
            CSR_PRMD:   r = {29'b0, m_pie, m_pplv};
            CSR_ECFG:   r = {19'b0, m_lie};
            CSR_ESTAT:  r = {9'b0, m_esub, m_ecode, 3'b0, int_vector()};
            CSR_ERA:    r = m_era;
            CSR_EENTRY: r = m_eentry;
            CSR_SAVE0:  r = m_save[0];
            CSR_SAVE1:  r = m_save[1];
            CSR_SAVE2:  r = m_save[2];
            CSR_SAVE3:  r = m_save[3];
            CSR_TID:    r = m_tid;
            CSR_TCFG:   r = m_tcfg;
            default:    r = '0;
        endcase
        return r;
    endfunction

    // one clock of writes and strobes, events beat software
    task automatic model_cycle(input csr_wr_t w, input exc_ctl_t c);
        csr_word_t nw;
        nw = '0;
        if (c.restore_state) begin
            m_plv = m_pplv;
            m_ie  = m_pie;
        end else if (c.store_state) begin
            m_pplv = m_plv;
            m_pie  = m_ie;
            m_plv  = '0;
            m_ie   = 1'b0;
        end else if (w.en && w.addr == CSR_CRMD) begin
            nw    = merge_bits(expected_rdata(CSR_CRMD), w.data, w.mask);
            m_plv = nw[1:0];
            m_ie  = nw[2];
            if (nw[3] != nw[4]) begin
                m_da = nw[3];
                m_pg = nw[4];
            end
        end
        if (w.en && w.addr == CSR_PRMD && !(c.store_state && !c.restore_state)) begin
            nw     = merge_bits(expected_rdata(CSR_PRMD), w.data, w.mask);
            m_pplv = nw[1:0];
            m_pie  = nw[2];
        end
        if (c.ecode_we) begin
            m_ecode = c.ecode_in[5:0];
            m_esub  = (c.ecode_in[5:0] != 0) ? c.ecode_in[6] : 1'b0;
        end else if (w.en && w.addr == CSR_ESTAT) begin
            nw      = merge_bits({30'b0, m_sw_is}, w.data, w.mask);
            m_sw_is = nw[1:0];
        end
        if (c.era_we) begin
            m_era = c.era_in;
        end else if (w.en && w.addr == CSR_ERA) begin
            m_era = merge_bits(m_era, w.data, w.mask);
        end
        if (w.en) begin
            case (w.addr)
                CSR_ECFG: begin
                    nw    = merge_bits({19'b0, m_lie}, w.data, w.mask & LIE_BITS);
                    m_lie = nw[12:0];
                end
                CSR_EENTRY: m_eentry = merge_bits(m_eentry, w.data, w.mask) & 32'hffff_ffc0;
                CSR_SAVE0:  m_save[0] = merge_bits(m_save[0], w.data, w.mask);
                CSR_SAVE1:  m_save[1] = merge_bits(m_save[1], w.data, w.mask);
                CSR_SAVE2:  m_save[2] = merge_bits(m_save[2], w.data, w.mask);
                CSR_SAVE3:  m_save[3] = merge_bits(m_save[3], w.data, w.mask);
                CSR_TID:    m_tid = merge_bits(m_tid, w.data, w.mask);
                CSR_TCFG:   m_tcfg = merge_bits(m_tcfg, w.data, w.mask);
                CSR_TICLR: begin
                    if (w.mask[0] && w.data[0]) begin
                        m_timer_int = 1'b0;
                    end
                end
                default: ;
            endcase
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus helpers, all start and end 1 ns after an edge
    //////////////////////////////////////////////////
    task automatic drive_cycle(input csr_wr_t w, input exc_ctl_t c);
        csr_wr  = w;
        exc_ctl = c;
        model_cycle(w, c);
        @(posedge clk);
        #1;
        csr_wr  = '0;
        exc_ctl = '0;
    endtask

    task automatic write_csr(input csr_addr_t a, input csr_word_t d, input csr_word_t m);
        drive_cycle('{en: 1'b1, addr: a, mask: m, data: d}, '0);
    endtask

    task automatic check_read(input csr_addr_t a);
        raddr   = a;
        chk_exp = expected_rdata(a);
        chk_en  = 1'b1;
        @(posedge clk);
        #1;
        chk_en = 1'b0;
    endtask

    task automatic check_outputs();
        logic exp_idle;
        logic exp_cpu;
        exp_idle = |int_vector();
        exp_cpu  = m_ie & (|(m_lie & int_vector()));
        @(negedge clk);
        chk_cnt++;
        assert (has_interrupt_idle === exp_idle && has_interrupt_cpu === exp_cpu) else begin
            err_cnt++;
            $display("[FAIL] %0t: idle/cpu irq %b/%b, expected %b/%b", $time,
                     has_interrupt_idle, has_interrupt_cpu, exp_idle, exp_cpu);
        end
        assert (translate_mode === trans_mode_e'({m_pg, m_da}) && plv === m_plv) else begin
            err_cnt++;
            $display("[FAIL] %0t: mode %b plv %0d, expected %b plv %0d", $time,
                     translate_mode, plv, {m_pg, m_da}, m_plv);
        end
        assert (ecode === m_ecode && era_out === m_era && eentry === m_eentry
                && tid === m_tid) else begin
            err_cnt++;
            $display("[FAIL] %0t: ecode/era/eentry/tid ports differ from the model", $time);
        end
        @(posedge clk);
        #1;
    endtask

    // comparing process, reads settle well before the falling edge
    always @(negedge clk) begin
        if (chk_en) begin
            chk_cnt++;
            assert (rdata === chk_exp) else begin
                err_cnt++;
                $display("[FAIL] %0t: read 0x%0h gave 0x%08h, expected 0x%08h", $time,
                         raddr, rdata, chk_exp);
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        csr_addr_t rand_addrs [7];
        csr_word_t d;
        csr_word_t m;
        exc_ctl_t  c;
        int        wait_cnt;

        csr_wr       = '0;
        raddr        = '0;
        exc_ctl      = '0;
        hardware_int = '0;
        chk_en       = 1'b0;
        chk_exp      = '0;
        err_cnt      = 0;
        chk_cnt      = 0;
        seed         = 32'h9c04_c3d5;
        m_save       = '{default: '0};
        {m_tid, m_era, m_eentry, m_tcfg} = '0;
        {m_lie, m_sw_is, m_ecode, m_esub} = '0;
        {m_plv, m_pplv, m_ie, m_pie, m_pg, m_timer_int} = '0;
        m_da = 1'b1;
        rand_addrs = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_ERA, CSR_EENTRY};

        wait (rstn);
        @(posedge clk);
        #1;
        check_outputs();
        check_read(CSR_CRMD);

        // masked random writes
        for (int i = 0; i < 21; i++) begin
            d = $random(seed);
            m = $random(seed);
            write_csr(rand_addrs[i % 7], d, m);
            check_read(rand_addrs[i % 7]);
        end
        check_outputs();

        // store and restore through prmd
        write_csr(CSR_CRMD, 32'h0f, 32'h1f);
        check_read(CSR_CRMD);
        c = '0;
        c.store_state = 1'b1;
        drive_cycle('0, c);
        check_read(CSR_CRMD);
        check_read(CSR_PRMD);
        write_csr(CSR_CRMD, 32'h2, 32'h3);
        c = '0;
        c.restore_state = 1'b1;
        drive_cycle('0, c);
        check_read(CSR_CRMD);
        check_read(CSR_PRMD);
        write_csr(CSR_CRMD, 32'h1, 32'h7);
        c.store_state = 1'b1;
        drive_cycle('0, c);
        check_read(CSR_CRMD);
        check_read(CSR_PRMD);
        check_outputs();

        // translation mode, da == pg is refused
        write_csr(CSR_CRMD, 32'h18, 32'h18);
        check_outputs();
        write_csr(CSR_CRMD, 32'h10, 32'h18);
        check_outputs();
        write_csr(CSR_CRMD, 32'h00, 32'h18);
        check_outputs();
        check_read(CSR_CRMD);
        write_csr(CSR_CRMD, 32'h08, 32'h18);
        check_outputs();

        // exception code and era priority
        c = '0;
        c.ecode_we = 1'b1;
        c.ecode_in = 7'h45;
        drive_cycle('0, c);
        check_read(CSR_ESTAT);
        c.ecode_in = 7'h40;
        drive_cycle('0, c);
        check_read(CSR_ESTAT);
        c.ecode_in = 7'h0a;
        drive_cycle('{en: 1'b1, addr: CSR_ESTAT, mask: 32'h3, data: 32'h3}, c);
        check_read(CSR_ESTAT);
        c = '0;
        c.era_we = 1'b1;
        c.era_in = 32'h1c00_0040;
        drive_cycle('{en: 1'b1, addr: CSR_ERA, mask: '1, data: 32'hdead_beef}, c);
        check_read(CSR_ERA);
        check_outputs();

        // interrupt lines against ie and lie
        hardware_int = 8'h04;
        check_outputs();
        check_read(CSR_ESTAT);
        write_csr(CSR_ECFG, 32'h10, '1);
        check_outputs();
        write_csr(CSR_CRMD, 32'h0, 32'h4);
        check_outputs();
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        hardware_int = 8'h00;
        write_csr(CSR_ESTAT, 32'h2, 32'h3);
        check_outputs();
        write_csr(CSR_ECFG, '1, '1);
        check_read(CSR_ECFG);
        check_outputs();
        write_csr(CSR_ESTAT, 32'h0, 32'h3);
        check_outputs();

        // one-shot timer
        write_csr(CSR_TCFG, (TIMER_INIT << 2) | 32'h1, '1);
        wait_cnt = 0;
        @(negedge clk);
        while (!has_interrupt_idle && wait_cnt < TIMER_LAT + 2) begin
            @(negedge clk);
            wait_cnt++;
        end
        chk_cnt++;
        assert (has_interrupt_idle && wait_cnt >= TIMER_LAT - 2) else begin
            err_cnt++;
            $display("[FAIL] %0t: timer irq after %0d cycles, expected %0d +/- 2", $time,
                     wait_cnt, TIMER_LAT);
        end
        @(posedge clk);
        #1;
        m_timer_int = 1'b1;
        check_outputs();
        check_read(CSR_ESTAT);
        check_read(CSR_TCFG);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        check_outputs();
        check_read(CSR_TICLR);
        check_read(CSR_ESTAT);
        check_read(14'h7);
        check_read(14'h3fff);

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

//--- vlog.f
logic/csr_pkg.sv
logic/csr_mode_ctrl.sv
logic/csr_timer.sv
logic/csr_exc_regs.sv
logic/csr_scratch_regs.sv
logic/csr_read_port.sv
logic/csr_top.sv
test/tb_clock_gen.sv
test/csr_tb.sv
